//--- common/modem_cfg_pkg.sv
package modem_cfg_pkg;

    // host register words and configuration inputs
    localparam int REG_W = 32;

    typedef logic [7:0] func_code_t;

    ////////////////////////////////////////
    // mode codes
    ////////////////////////////////////////

    // zero and anything above 3 leave every lane idle
    localparam func_code_t MODE_FSK  = 8'h01;
    localparam func_code_t MODE_QPSK = 8'h02;
    localparam func_code_t MODE_BPSK = 8'h03;

    ////////////////////////////////////////
    // data source codes
    ////////////////////////////////////////

    // 1024-point snapshot while transmitting
    localparam func_code_t SRC_SNAPSHOT = 8'h00;
    // decimated full baseband stream
    localparam func_code_t SRC_STREAM   = 8'h01;

    // registered function codes
    typedef struct packed {
        func_code_t mode;
        func_code_t data_src;
        func_code_t code_type;
        func_code_t trans_type;
    } func_cfg_t;

    // one-hot modulator select, all zero when no lane is chosen
    typedef struct packed {
        logic fsk;
        logic qpsk;
        logic bpsk;
    } lane_sel_t;

endpackage

//--- common/baseband_pkg.sv
package baseband_pkg;

    // one complex baseband sample
    typedef struct packed {
        logic [11:0] i;
        logic [11:0] q;
    } iq_t;

    // what a modulator hands back
    typedef struct packed {
        iq_t  iq;
        logic ready;
        logic queue_valid;
    } lane_out_t;

    // what a modulator is fed
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } lane_in_t;

    // lane order is fsk, qpsk, bpsk
    localparam int NUM_LANES = 3;

    ////////////////////////////////////////
    // capture records and counters
    ////////////////////////////////////////

    typedef struct packed {
        logic [35:0] pad_hi;
        logic [11:0] i;
        logic [3:0]  pad_lo;
        logic [11:0] q;
    } record_t;

    typedef logic [31:0] count_t;

    // strobe period in clocks
    localparam int SAMPLE_DIV     = 32;
    localparam int SNAPSHOT_LEN   = 1024;
    localparam int STREAM_PHASE_W = 5;

endpackage

//--- verilog/func_code_regs.sv
`timescale 1ns/10ps

module func_code_regs (
    input  logic                                 l_clk,
    input  logic                                 rst_n,
    input  logic [modem_cfg_pkg::REG_W-1:0]      mode_in_i,
    input  logic [modem_cfg_pkg::REG_W-1:0]      data_in_i,
    input  logic [modem_cfg_pkg::REG_W-1:0]      code_in_i,
    input  logic [modem_cfg_pkg::REG_W-1:0]      trans_in_i,
    input  logic [modem_cfg_pkg::REG_W-1:0]      capture_en_i,
    input  logic [modem_cfg_pkg::REG_W-1:0]      clear_in_i,
    output modem_cfg_pkg::func_cfg_t             cfg_o,
    output modem_cfg_pkg::lane_sel_t             lane_sel_o,
    output logic                                 mem_clear_o,
    output logic                                 lane_start_o,
    output logic [3:0][modem_cfg_pkg::REG_W-1:0] cfg_rb_o
);
    import modem_cfg_pkg::*;

    func_cfg_t  cfg_q;
    lane_sel_t  lane_sel_q;
    logic       mem_clear_q;
    logic [1:0] cap_en_q;
    logic       cap_rise;

    // function codes live in the low byte of each host word
    always_ff @(posedge l_clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else begin
            cfg_q.mode       <= mode_in_i[7:0];
            cfg_q.data_src   <= data_in_i[7:0];
            cfg_q.code_type  <= code_in_i[7:0];
            cfg_q.trans_type <= trans_in_i[7:0];
        end
    end

    // mode decode one more clock behind the code register
    always_ff @(posedge l_clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_sel_q <= '0;
        end else begin
            lane_sel_q <= '0;
            case (cfg_q.mode)
                MODE_FSK:  lane_sel_q.fsk  <= 1'b1;
                MODE_QPSK: lane_sel_q.qpsk <= 1'b1;
                MODE_BPSK: lane_sel_q.bpsk <= 1'b1;
                default:   lane_sel_q      <= '0;
            endcase
        end
    end

    // manual clear bit and capture enable history
    always_ff @(posedge l_clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_clear_q <= 1'b0;
            cap_en_q    <= 2'b00;
        end else begin
            mem_clear_q <= clear_in_i[0];
            cap_en_q    <= {cap_en_q[0], capture_en_i[0]};
        end
    end

    assign cap_rise = cap_en_q[0] & ~cap_en_q[1];

    // modulators free-run unless the stream source waits for a capture edge
    assign lane_start_o = (cfg_q.data_src == SRC_STREAM) ? cap_rise : 1'b1;

    assign cfg_o       = cfg_q;
    assign lane_sel_o  = lane_sel_q;
    assign mem_clear_o = mem_clear_q;

    assign cfg_rb_o[0] = REG_W'(cfg_q.mode);
    assign cfg_rb_o[1] = REG_W'(cfg_q.data_src);
    assign cfg_rb_o[2] = REG_W'(cfg_q.code_type);
    assign cfg_rb_o[3] = REG_W'(cfg_q.trans_type);

    // lane select is one-hot or idle
    a_lane_sel_onehot: assert property (@(posedge l_clk) disable iff (!rst_n)
        $onehot0(lane_sel_q));

endmodule

//--- verilog/mod_lane_router.sv
`timescale 1ns/10ps

module mod_lane_router (
    input  logic                      l_clk,
    input  logic                      rst_n,
    input  logic                      mem_clear_i,
    input  modem_cfg_pkg::func_code_t mode_i,
    input  modem_cfg_pkg::lane_sel_t  lane_sel_i,
    input  logic [7:0]                byte_i,
    input  logic                      byte_valid_i,
    input  baseband_pkg::lane_out_t   lanes_i [baseband_pkg::NUM_LANES],
    output baseband_pkg::lane_in_t    lanes_o [baseband_pkg::NUM_LANES],
    output logic                      byte_ready_o,
    output baseband_pkg::iq_t         sel_iq_o,
    output logic                      sel_queue_valid_o
);
    import modem_cfg_pkg::*;
    import baseband_pkg::*;

    // mode code owning each lane, in lane order
    localparam func_code_t LANE_MODE [NUM_LANES] = '{MODE_FSK, MODE_QPSK, MODE_BPSK};

    logic [NUM_LANES-1:0] sel_vec;

    // index 0 is fsk
    assign sel_vec = {lane_sel_i.bpsk, lane_sel_i.qpsk, lane_sel_i.fsk};

    ////////////////////////////////////////
    // byte stream steering
    ////////////////////////////////////////

    always_comb begin
        byte_ready_o = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            lanes_o[k].data  = sel_vec[k] ? byte_i : 8'h00;
            lanes_o[k].valid = sel_vec[k] & byte_valid_i;
            byte_ready_o     = byte_ready_o | (sel_vec[k] & lanes_i[k].ready);
        end
    end

    ////////////////////////////////////////
    // selected lane samples for capture
    ////////////////////////////////////////

    always_ff @(posedge l_clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_iq_o          <= '0;
            sel_queue_valid_o <= 1'b0;
        end else if (mem_clear_i) begin
            sel_iq_o          <= '0;
            sel_queue_valid_o <= 1'b0;
        end else begin
            // unknown modes hold zero
            sel_iq_o          <= '0;
            sel_queue_valid_o <= 1'b0;
            for (int k = 0; k < NUM_LANES; k++) begin
                if (mode_i == LANE_MODE[k]) begin
                    sel_iq_o          <= lanes_i[k].iq;
                    sel_queue_valid_o <= lanes_i[k].queue_valid;
                end
            end
        end
    end

    // a lane sees valid only if the mode one clock back named it
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane_chk
        a_idle_lane_quiet: assert property (@(posedge l_clk) disable iff (!rst_n)
            lanes_o[k].valid |-> ($past(mode_i) == LANE_MODE[k]));
    end

endmodule

//--- capture/baseband_capture.sv
`timescale 1ns/10ps

module baseband_capture (
    input  logic                      l_clk,
    input  logic                      rst_n,
    input  logic                      mem_clear_i,
    input  modem_cfg_pkg::func_code_t data_src_i,
    input  logic                      capture_en_i,
    input  logic                      byte_valid_i,
    input  baseband_pkg::iq_t         sel_iq_i,
    input  logic                      sel_queue_valid_i,
    input  logic                      rec_ready_i,
    output baseband_pkg::record_t     rec_o,
    output logic                      rec_valid_o,
    output logic                      snap_hit_o,
    output logic                      stream_hit_o
);
    import modem_cfg_pkg::*;
    import baseband_pkg::*;

    localparam int DIV_W  = $clog2(SAMPLE_DIV);
    localparam int SNAP_W = $clog2(SNAPSHOT_LEN) + 1;

    logic [DIV_W-1:0]          samp_phase;
    logic                      strobe;
    logic                      snap_arm;
    logic [SNAP_W-1:0]         snap_cnt;
    record_t                   snap_rec;
    logic                      snap_valid;
    logic                      stream_arm;
    logic [STREAM_PHASE_W-1:0] stream_phase;
    record_t                   stream_rec;
    logic                      stream_valid;
    record_t                   out_rec;
    logic                      out_valid;

    // i and q into their record slots, padding zero
    function automatic record_t pack_iq(iq_t s);
        record_t r;
        r   = '0;
        r.i = s.i;
        r.q = s.q;
        return r;
    endfunction

    ////////////////////////////////////////
    // sampling strobe
    ////////////////////////////////////////

    always_ff @(posedge l_clk or negedge rst_n) begin
        if (!rst_n) begin
            samp_phase <= '0;
            strobe     <= 1'b0;
        end else if (mem_clear_i) begin
            samp_phase <= '0;
            strobe     <= 1'b0;
        end else begin
            if (samp_phase == DIV_W'(SAMPLE_DIV - 1)) begin
                samp_phase <= '0;
            end else begin
                samp_phase <= samp_phase + 1'b1;
            end
            strobe <= (samp_phase == DIV_W'(SAMPLE_DIV - 1));
        end
    end

    ////////////////////////////////////////
    // snapshot path
    ////////////////////////////////////////

    always_ff @(posedge l_clk or negedge rst_n) begin
        if (!rst_n) begin
            snap_arm   <= 1'b0;
            snap_cnt   <= '0;
            snap_rec   <= '0;
            snap_valid <= 1'b0;
        end else if (mem_clear_i) begin
            snap_arm   <= 1'b0;
            snap_cnt   <= '0;
            snap_rec   <= '0;
            snap_valid <= 1'b0;
        end else begin
            snap_arm   <= byte_valid_i && (data_src_i == SRC_SNAPSHOT) && capture_en_i;
            snap_rec   <= '0;
            snap_valid <= 1'b0;
            if (!snap_arm) begin
                snap_cnt <= '0;
            end else if (strobe && (snap_cnt < SNAP_W'(SNAPSHOT_LEN))) begin
                // count saturates at the snapshot length
                snap_cnt   <= snap_cnt + 1'b1;
                snap_rec   <= pack_iq(sel_iq_i);
                snap_valid <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // stream path, one record per 32 armed clocks
    ////////////////////////////////////////

    always_ff @(posedge l_clk or negedge rst_n) begin
        if (!rst_n) begin
            stream_arm   <= 1'b0;
            stream_phase <= '0;
            stream_rec   <= '0;
            stream_valid <= 1'b0;
        end else if (mem_clear_i) begin
            stream_arm   <= 1'b0;
            stream_phase <= '0;
            stream_rec   <= '0;
            stream_valid <= 1'b0;
        end else begin
            stream_arm   <= (data_src_i == SRC_STREAM) && sel_queue_valid_i;
            stream_rec   <= '0;
            stream_valid <= 1'b0;
            if (!stream_arm) begin
                stream_phase <= '0;
            end else begin
                stream_phase <= stream_phase + 1'b1;
                if (stream_phase == '0) begin
                    stream_rec   <= pack_iq(sel_iq_i);
                    stream_valid <= 1'b1;
                end
            end
        end
    end

    // output selector
    always_ff @(posedge l_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_rec   <= '0;
            out_valid <= 1'b0;
        end else if (mem_clear_i) begin
            out_rec   <= '0;
            out_valid <= 1'b0;
        end else begin
            case (data_src_i)
                SRC_SNAPSHOT: begin
                    out_rec   <= snap_rec;
                    out_valid <= snap_valid;
                end
                SRC_STREAM: begin
                    out_rec   <= stream_rec;
                    out_valid <= stream_valid;
                end
                default: begin
                    out_rec   <= '0;
                    out_valid <= 1'b0;
                end
            endcase
        end
    end

    // no back-pressure, a record shown while not ready is dropped
    assign rec_o        = out_rec;
    assign rec_valid_o  = out_valid & rec_ready_i;
    assign snap_hit_o   = snap_valid;
    assign stream_hit_o = stream_valid;

    // each snapshot hit lands inside the armed window and the length limit
    a_snap_bounded: assert property (@(posedge l_clk) disable iff (!rst_n)
        snap_valid |-> $past(snap_arm) && (snap_cnt inside {[1:SNAPSHOT_LEN]}));

endmodule

//--- capture/capture_counters.sv
`timescale 1ns/10ps

module capture_counters (
    input  logic                  l_clk,
    input  logic                  rst_n,
    input  logic                  mem_clear_i,
    input  logic                  capture_en_i,
    input  logic                  byte_fire_i,
    input  logic                  snap_hit_i,
    input  logic                  stream_hit_i,
    output baseband_pkg::count_t  byte_cnt_o,
    output baseband_pkg::count_t  snap_cnt_o,
    output baseband_pkg::count_t  stream_cnt_o
);

    // bytes taken from the host file
    always_ff @(posedge l_clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt_o <= '0;
        end else if (mem_clear_i) begin
            byte_cnt_o <= '0;
        end else if (byte_fire_i) begin
            byte_cnt_o <= byte_cnt_o + 1'b1;
        end
    end

    ////////////////////////////////////////
    // record counters, held at zero without capture enable
    ////////////////////////////////////////

    always_ff @(posedge l_clk or negedge rst_n) begin
        if (!rst_n) begin
            snap_cnt_o   <= '0;
            stream_cnt_o <= '0;
        end else if (mem_clear_i || !capture_en_i) begin
            snap_cnt_o   <= '0;
            stream_cnt_o <= '0;
        end else begin
            if (snap_hit_i) begin
                snap_cnt_o <= snap_cnt_o + 1'b1;
            end
            if (stream_hit_i) begin
                stream_cnt_o <= stream_cnt_o + 1'b1;
            end
        end
    end

endmodule

//--- verilog/baseband_ctrl_top.sv
`timescale 1ns/10ps

module baseband_ctrl_top (
    input  logic                                 l_clk,
    input  logic                                 rst_n,
    input  logic [modem_cfg_pkg::REG_W-1:0]      mode_in_i,
    input  logic [modem_cfg_pkg::REG_W-1:0]      data_in_i,
    input  logic [modem_cfg_pkg::REG_W-1:0]      code_in_i,
    input  logic [modem_cfg_pkg::REG_W-1:0]      trans_in_i,
    input  logic [modem_cfg_pkg::REG_W-1:0]      capture_en_i,
    input  logic [modem_cfg_pkg::REG_W-1:0]      clear_in_i,
    input  logic [7:0]                           byte_i,
    input  logic                                 byte_valid_i,
    output logic                                 byte_ready_o,
    input  baseband_pkg::lane_out_t              lanes_i [baseband_pkg::NUM_LANES],
    input  logic                                 rec_ready_i,
    output baseband_pkg::lane_in_t               lanes_o [baseband_pkg::NUM_LANES],
    output logic                                 lane_start_o,
    output modem_cfg_pkg::func_code_t            code_type_o,
    output logic                                 lane_clear_o,
    output logic [3:0][modem_cfg_pkg::REG_W-1:0] cfg_rb_o,
    output baseband_pkg::record_t                rec_o,
    output logic                                 rec_valid_o,
    output baseband_pkg::count_t                 byte_cnt_o,
    output baseband_pkg::count_t                 snap_cnt_o,
    output baseband_pkg::count_t                 stream_cnt_o
);
    import modem_cfg_pkg::*;
    import baseband_pkg::*;

    func_cfg_t cfg;
    lane_sel_t lane_sel;
    logic      mem_clear;
    iq_t       sel_iq;
    logic      sel_queue_valid;
    logic      byte_fire;
    logic      snap_hit;
    logic      stream_hit;

    assign byte_fire    = byte_valid_i & byte_ready_o;
    assign code_type_o  = cfg.code_type;
    assign lane_clear_o = mem_clear;

    func_code_regs u_regs (
        .l_clk        (l_clk),
        .rst_n        (rst_n),
        .mode_in_i    (mode_in_i),
        .data_in_i    (data_in_i),
        .code_in_i    (code_in_i),
        .trans_in_i   (trans_in_i),
        .capture_en_i (capture_en_i),
        .clear_in_i   (clear_in_i),
        .cfg_o        (cfg),
        .lane_sel_o   (lane_sel),
        .mem_clear_o  (mem_clear),
        .lane_start_o (lane_start_o),
        .cfg_rb_o     (cfg_rb_o)
    );

    mod_lane_router u_router (
        .l_clk             (l_clk),
        .rst_n             (rst_n),
        .mem_clear_i       (mem_clear),
        .mode_i            (cfg.mode),
        .lane_sel_i        (lane_sel),
        .byte_i            (byte_i),
        .byte_valid_i      (byte_valid_i),
        .lanes_i           (lanes_i),
        .lanes_o           (lanes_o),
        .byte_ready_o      (byte_ready_o),
        .sel_iq_o          (sel_iq),
        .sel_queue_valid_o (sel_queue_valid)
    );

    baseband_capture u_capture (
        .l_clk             (l_clk),
        .rst_n             (rst_n),
        .mem_clear_i       (mem_clear),
        .data_src_i        (cfg.data_src),
        .capture_en_i      (capture_en_i[0]),
        .byte_valid_i      (byte_valid_i),
        .sel_iq_i          (sel_iq),
        .sel_queue_valid_i (sel_queue_valid),
        .rec_ready_i       (rec_ready_i),
        .rec_o             (rec_o),
        .rec_valid_o       (rec_valid_o),
        .snap_hit_o        (snap_hit),
        .stream_hit_o      (stream_hit)
    );

    capture_counters u_counters (
        .l_clk        (l_clk),
        .rst_n        (rst_n),
        .mem_clear_i  (mem_clear),
        .capture_en_i (capture_en_i[0]),
        .byte_fire_i  (byte_fire),
        .snap_hit_i   (snap_hit),
        .stream_hit_i (stream_hit),
        .byte_cnt_o   (byte_cnt_o),
        .snap_cnt_o   (snap_cnt_o),
        .stream_cnt_o (stream_cnt_o)
    );

endmodule

//--- testbench/tb_baseband_model.sv
package tb_baseband_model;

    import modem_cfg_pkg::*;
    import baseband_pkg::*;

    // inputs applied to the DUT during one clock
    typedef struct packed {
        logic [REG_W-1:0]            mode;
        logic [REG_W-1:0]            data;
        logic [REG_W-1:0]            code;
        logic [REG_W-1:0]            trans;
        logic [REG_W-1:0]            cap_en;
        logic [REG_W-1:0]            clear;
        logic [7:0]                  data_byte;
        logic                        byte_valid;
        lane_out_t [NUM_LANES-1:0]   lanes;
        logic                        rec_ready;
    } stim_t;

    // every register of the control block
    typedef struct packed {
        func_cfg_t   cfg;
        lane_sel_t   lane_sel;
        logic        mem_clear;
        logic [1:0]  cap_en;
        iq_t         sel_iq;
        logic        sel_qv;
        logic [4:0]  samp_phase;
        logic        strobe;
        logic        snap_arm;
        logic [10:0] snap_cnt;
        iq_t         snap_iq;
        logic        snap_valid;
        logic        stream_arm;
        logic [4:0]  stream_phase;
        iq_t         stream_iq;
        logic        stream_valid;
        record_t     out_rec;
        logic        out_valid;
        count_t      byte_cnt;
        count_t      snap_cnt_o;
        count_t      stream_cnt_o;
    } model_t;

    function automatic int lane_index(func_code_t mode);
        return (mode == MODE_FSK) ? 0 : (mode == MODE_QPSK) ? 1 : (mode == MODE_BPSK) ? 2 : -1;
    endfunction

    function automatic logic lane_picked(lane_sel_t sel, int k);
        return (k == 0) ? sel.fsk : (k == 1) ? sel.qpsk : sel.bpsk;
    endfunction

    function automatic record_t to_record(iq_t s);
        return {36'h0, s.i, 4'h0, s.q};
    endfunction

    function automatic logic lane_ready(model_t s, stim_t x);
        logic r;
        r = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            r = r | (lane_picked(s.lane_sel, k) & x.lanes[k].ready);
        end
        return r;
    endfunction

    function automatic lane_in_t lane_drive(model_t s, stim_t x, int k);
        lane_in_t d;
        d.data  = lane_picked(s.lane_sel, k) ? x.data_byte : 8'h00;
        d.valid = lane_picked(s.lane_sel, k) & x.byte_valid;
        return d;
    endfunction

    // stream source waits for a capture edge, otherwise held high
    function automatic logic start_level(model_t s);
        return (s.cfg.data_src == SRC_STREAM) ? (s.cap_en[0] & ~s.cap_en[1]) : 1'b1;
    endfunction

    // random modulator outputs, queue mostly valid so the stream stays armed
    function automatic lane_out_t lane_stub();
        lane_out_t   o;
        logic [31:0] r;
        r             = $urandom();
        o.iq          = r[23:0];
        o.ready       = ($urandom_range(0, 3) != 0);
        o.queue_valid = ($urandom_range(0, 63) != 0);
        return o;
    endfunction

    ////////////////////////////////////////
    // one clock of the control block
    ////////////////////////////////////////

    function automatic model_t model_step(model_t s, stim_t x);
        model_t n;
        model_t c;
        int     k;
        n = s;
        k = lane_index(s.cfg.mode);
        n.cfg       = {x.mode[7:0], x.data[7:0], x.code[7:0], x.trans[7:0]};
        n.lane_sel  = (k >= 0) ? lane_sel_t'(3'b100 >> k) : '0;
        n.mem_clear = x.clear[0];
        n.cap_en    = {s.cap_en[0], x.cap_en[0]};
        n.sel_iq    = (k >= 0) ? x.lanes[k].iq : '0;
        n.sel_qv    = (k >= 0) ? x.lanes[k].queue_valid : 1'b0;

        // strobe in the cycle after phase 31
        n.strobe     = (s.samp_phase == 5'd31);
        n.samp_phase = s.samp_phase + 5'd1;

        n.snap_arm   = x.byte_valid && (s.cfg.data_src == SRC_SNAPSHOT) && x.cap_en[0];
        n.snap_valid = s.snap_arm && s.strobe && (s.snap_cnt < SNAPSHOT_LEN);
        n.snap_iq    = n.snap_valid ? s.sel_iq : '0;
        n.snap_cnt   = s.snap_arm ? s.snap_cnt + 11'(n.snap_valid) : 11'd0;

        n.stream_arm   = (s.cfg.data_src == SRC_STREAM) && s.sel_qv;
        n.stream_valid = s.stream_arm && (s.stream_phase == 5'd0);
        n.stream_iq    = n.stream_valid ? s.sel_iq : '0;
        n.stream_phase = s.stream_arm ? s.stream_phase + 5'd1 : 5'd0;

        n.out_rec   = '0;
        n.out_valid = 1'b0;
        if (s.cfg.data_src == SRC_SNAPSHOT) begin
            n.out_rec   = to_record(s.snap_iq);
            n.out_valid = s.snap_valid;
        end else if (s.cfg.data_src == SRC_STREAM) begin
            n.out_rec   = to_record(s.stream_iq);
            n.out_valid = s.stream_valid;
        end

        n.byte_cnt = s.byte_cnt + count_t'(x.byte_valid && lane_ready(s, x));
        if (!x.cap_en[0]) begin
            n.snap_cnt_o   = '0;
            n.stream_cnt_o = '0;
        end else begin
            n.snap_cnt_o   = s.snap_cnt_o + count_t'(s.snap_valid);
            n.stream_cnt_o = s.stream_cnt_o + count_t'(s.stream_valid);
        end

        // memory clear spares only the function-code block
        if (s.mem_clear) begin
            c           = '0;
            c.cfg       = n.cfg;
            c.lane_sel  = n.lane_sel;
            c.mem_clear = n.mem_clear;
            c.cap_en    = n.cap_en;
            n           = c;
        end
        return n;
    endfunction

endpackage

//--- testbench/tb_baseband_ctrl.sv
`timescale 1ns/10ps

module tb_baseband_ctrl;

    import modem_cfg_pkg::*;
    import baseband_pkg::*;
    import tb_baseband_model::*;

    logic                  l_clk;
    logic                  rst_n;
    stim_t                 cur;
    model_t                st;
    lane_out_t             lanes_in [NUM_LANES];
    lane_in_t              lanes_out [NUM_LANES];
    logic                  byte_ready;
    logic                  lane_start;
    logic                  lane_clear;
    logic                  rec_valid;
    func_code_t            code_type;
    logic [3:0][REG_W-1:0] cfg_rb;
    record_t               rec;
    count_t                byte_cnt;
    count_t                snap_cnt;
    count_t                stream_cnt;

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign lanes_in[g] = cur.lanes[g];
    end

    baseband_ctrl_top dut (
        .l_clk        (l_clk),
        .rst_n        (rst_n),
        .mode_in_i    (cur.mode),
        .data_in_i    (cur.data),
        .code_in_i    (cur.code),
        .trans_in_i   (cur.trans),
        .capture_en_i (cur.cap_en),
        .clear_in_i   (cur.clear),
        .byte_i       (cur.data_byte),
        .byte_valid_i (cur.byte_valid),
        .byte_ready_o (byte_ready),
        .lanes_i      (lanes_in),
        .rec_ready_i  (cur.rec_ready),
        .lanes_o      (lanes_out),
        .lane_start_o (lane_start),
        .code_type_o  (code_type),
        .lane_clear_o (lane_clear),
        .cfg_rb_o     (cfg_rb),
        .rec_o        (rec),
        .rec_valid_o  (rec_valid),
        .byte_cnt_o   (byte_cnt),
        .snap_cnt_o   (snap_cnt),
        .stream_cnt_o (stream_cnt)
    );

    initial begin
        l_clk = 1'b0;
        forever #5 l_clk = ~l_clk;
    end

    task automatic fail_stop(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_word(string name, logic [REG_W-1:0] exp, logic [REG_W-1:0] act);
        if (act !== exp) begin
            fail_stop($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            fail_stop($sformatf("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act));
        end
    endtask

    task automatic check_lane(string name, lane_in_t exp, lane_in_t act);
        if (act !== exp) begin
            fail_stop($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_record(record_t exp_rec, logic exp_v, record_t act_rec, logic act_v);
        if (act_rec !== exp_rec) begin
            fail_stop($sformatf("[FAIL] %0t rec_o expected %h actual %h",
                                $time, exp_rec, act_rec));
        end
        check_bit("rec_valid_o", exp_v, act_v);
    endtask

    task automatic check_count(string name, count_t exp, count_t act);
        if (act !== exp) begin
            fail_stop($sformatf("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act));
        end
    endtask

    task automatic check_outputs();
        for (int k = 0; k < 4; k++) begin
            check_word($sformatf("cfg_rb_o[%0d]", k), REG_W'(st.cfg[31 - 8 * k -: 8]), cfg_rb[k]);
        end
        check_word("code_type_o", REG_W'(st.cfg.code_type), REG_W'(code_type));
        for (int k = 0; k < NUM_LANES; k++) begin
            check_lane($sformatf("lanes_o[%0d]", k), lane_drive(st, cur, k), lanes_out[k]);
        end
        check_bit("byte_ready_o", lane_ready(st, cur), byte_ready);
        check_bit("lane_start_o", start_level(st), lane_start);
        check_bit("lane_clear_o", st.mem_clear, lane_clear);
        check_record(st.out_rec, st.out_valid & cur.rec_ready, rec, rec_valid);
        check_count("byte_cnt_o", st.byte_cnt, byte_cnt);
        check_count("snap_cnt_o", st.snap_cnt_o, snap_cnt);
        check_count("stream_cnt_o", st.stream_cnt_o, stream_cnt);
    endtask

    // model steps on the edge and new inputs land 1 ns later
    task automatic clock_cycle(stim_t nxt);
        @(posedge l_clk);
        st = model_step(st, cur);
        #1;
        cur = nxt;
        #1;
        check_outputs();
    endtask

    function automatic stim_t make_stim(func_code_t mode, func_code_t src, logic cap,
                                        logic clear, int valid_pct);
        stim_t x;
        x.mode        = $urandom();
        x.mode[7:0]   = mode;
        x.data        = $urandom();
        x.data[7:0]   = src;
        x.code        = $urandom();
        x.trans       = $urandom();
        x.cap_en      = $urandom();
        x.cap_en[0]   = cap;
        x.clear       = $urandom();
        x.clear[0]    = clear;
        x.data_byte   = 8'($urandom());
        x.byte_valid  = ($urandom_range(0, 99) < valid_pct);
        x.rec_ready   = ($urandom_range(0, 3) != 0);
        for (int k = 0; k < NUM_LANES; k++) begin
            x.lanes[k] = lane_stub();
        end
        return x;
    endfunction

    // mostly legal modes with now and then an unused code
    function automatic func_code_t pick_mode();
        int r;
        r = $urandom_range(0, 4);
        return (r == 4) ? 8'($urandom_range(4, 255)) : 8'(r);
    endfunction

    initial begin
        int         waited;
        func_code_t mode;
        func_code_t src;
        logic       cap;
        void'($urandom(32'hc6c3_7542));
        rst_n = 1'b0;
        cur   = '0;
        st    = '0;
        repeat (3) @(posedge l_clk);
        #1 rst_n = 1'b1;
        #1 check_outputs();

        ////////////////////////////////////////
        // registers, lane routing, byte handshake
        ////////////////////////////////////////
        for (int c = 0; c < 400; c++) begin
            if (c % 16 == 0) begin
                mode = pick_mode();
                src  = 8'($urandom_range(0, 2));
                cap  = 1'($urandom_range(0, 1));
            end
            clock_cycle(make_stim(mode, src, cap, 1'b0, 60));
        end

        // new arming period starts from a zeroed record counter
        repeat (2) clock_cycle(make_stim(MODE_QPSK, SRC_SNAPSHOT, 1'b0, 1'b0, 100));

        // snapshot runs until the record limit
        waited = 0;
        while (snap_cnt != SNAPSHOT_LEN) begin
            if (waited == 40000) fail_stop("snapshot counter never reached 1024 records");
            clock_cycle(make_stim(MODE_QPSK, SRC_SNAPSHOT, 1'b1, 1'b0, 100));
            waited++;
        end
        repeat (300) clock_cycle(make_stim(MODE_QPSK, SRC_SNAPSHOT, 1'b1, 1'b0, 100));
        check_count("snap_cnt_o", SNAPSHOT_LEN, snap_cnt);

        // each stream round opens with a capture edge
        for (int r = 0; r < 6; r++) begin
            repeat (3) clock_cycle(make_stim(MODE_FSK, SRC_STREAM, 1'b0, 1'b0, 60));
            waited = 0;
            while (stream_cnt < 3) begin
                if (waited == 400) fail_stop("stream records stopped arriving");
                clock_cycle(make_stim(MODE_FSK, SRC_STREAM, 1'b1, 1'b0, 60));
                waited++;
            end
        end

        // snapshot records pile up beside the stream count
        repeat (100) clock_cycle(make_stim(MODE_BPSK, SRC_SNAPSHOT, 1'b1, 1'b0, 100));

        // manual memory clear
        repeat (4) clock_cycle(make_stim(MODE_BPSK, SRC_SNAPSHOT, 1'b1, 1'b1, 100));
        check_count("byte_cnt_o", '0, byte_cnt);
        check_count("snap_cnt_o", '0, snap_cnt);
        check_count("stream_cnt_o", '0, stream_cnt);
        check_record('0, 1'b0, rec, rec_valid);
        repeat (200) clock_cycle(make_stim(MODE_BPSK, SRC_SNAPSHOT, 1'b1, 1'b0, 100));

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- baseband_ctrl_top.f
common/modem_cfg_pkg.sv
common/baseband_pkg.sv
verilog/func_code_regs.sv
verilog/mod_lane_router.sv
capture/baseband_capture.sv
capture/capture_counters.sv
verilog/baseband_ctrl_top.sv
testbench/tb_baseband_model.sv
testbench/tb_baseband_ctrl.sv
